/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = erx_tb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* design/elink_pkg.sv */
// transaction packet layout shared by unpacker, router and testbench
package elink_pkg;

   //########################################
   // packet geometry
   //########################################
   localparam int pkt_w = 104;             // default packet width

   // field offsets inside the 104-bit packet
   localparam int access_bit   = 0;
   localparam int write_bit    = 1;
   localparam int datamode_lsb = 2;
   localparam int datamode_msb = 3;
   localparam int ctrlmode_lsb = 4;
   localparam int ctrlmode_msb = 7;
   localparam int dstaddr_lsb  = 8;
   localparam int dstaddr_msb  = 39;
   localparam int data_lsb     = 40;
   localparam int data_msb     = 71;
   localparam int srcaddr_lsb  = 72;
   localparam int srcaddr_msb  = 103;

   //########################################
   // transfer size
   //########################################
   typedef enum logic [1:0]
   {
      dm_byte   = 2'b00,                   // 8 bit
      dm_half   = 2'b01,                   // 16 bit
      dm_word   = 2'b10,                   // 32 bit
      dm_double = 2'b11                    // 64 bit, data plus srcaddr
   } datamode_e;

endpackage

/* design/erx_deframer.sv */
`timescale 1ns/1ns

// stage 1: word slots into a 112-bit sample
module erx_deframer
   import erx_pkg::*;
(
   input  logic                rx_lclk,
   input  logic                rst_n,
   input  logic                rx_frame,     // level, high while words arrive
   input  logic [word_w-1:0]   rx_word,
   output logic                sample_valid, // one cycle, sample complete
   output logic [sample_w-1:0] sample,
   output logic                sample_burst
);

   word_slot_e slot;                       // lane for the next word
   word_slot_e slot_nxt;
   logic       pkt_seen;                   // frame already gave a packet

   //########################################
   // slot pointer
   //########################################
   always_comb
   begin
      case (slot)
         slot6:   slot_nxt = slot3;        // anticipate burst
         default: slot_nxt = word_slot_e'(slot + 3'd1);
      endcase
   end

   always_ff @(posedge rx_lclk or negedge rst_n)
   begin
      if (!rst_n)
         slot <= slot0;
      else if (!rx_frame)
         slot <= slot0;                    // idle or dropped frame
      else
         slot <= slot_nxt;
   end

   //########################################
   // sample assembly
   //########################################
   always_ff @(posedge rx_lclk)
   begin
      if (rx_frame)
         sample[int'(slot)*word_w +: word_w] <= rx_word; // lane per slot
   end

   // completion strobe and burst tracking
   always_ff @(posedge rx_lclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sample_valid <= 1'b0;
         sample_burst <= 1'b0;
         pkt_seen     <= 1'b0;
      end
      else
      begin
         sample_valid <= rx_frame && (slot == slot6);
         if (!rx_frame)
            pkt_seen <= 1'b0;              // frame over
         else if (slot == slot6)
         begin
            sample_burst <= pkt_seen;      // earlier packet in this frame
            pkt_seen     <= 1'b1;
         end
      end
   end

   // pointer stays inside the seven lanes
   a_slot_range : assert property (
      @(posedge rx_lclk) disable iff (!rst_n)
      slot inside {slot0, slot1, slot2, slot3, slot4, slot5, slot6});

endmodule

/* design/erx_pkg.sv */
// deserializer types for the receive path
package erx_pkg;

   localparam int word_w   = 16;          // one rx_lclk sample, both edges
   localparam int sample_w = 7 * word_w;  // raw transfer, 112 bits

   // slot the next accepted word fills
   typedef enum logic [2:0]
   {
      slot0 = 3'd0,                       // ctrlmode, dstaddr top
      slot1 = 3'd1,
      slot2 = 3'd2,                       // access, write, datamode
      slot3 = 3'd3,                       // burst restarts here
      slot4 = 3'd4,
      slot5 = 3'd5,
      slot6 = 3'd6                        // last word, packet complete
   } word_slot_e;

endpackage

/* design/erx_router.sv */
`timescale 1ns/1ns

// stage 3: write/read steering, wait forwarding, overrun flag
module erx_router
   import elink_pkg::*;
#(
   parameter int PW = pkt_w
)
(
   input  logic          rx_lclk,
   input  logic          rst_n,
   input  logic          pkt_valid,
   input  logic [PW-1:0] pkt,
   input  logic          pkt_burst,
   input  logic          rx_wr_wait,    // core push-back, write side
   input  logic          rx_rd_wait,
   output logic          rx_wr_access,  // one cycle pulses
   output logic          rx_rd_access,
   output logic [PW-1:0] rx_packet,     // held until next packet
   output logic          rx_burst,
   output logic          rxo_wr_wait,   // toward transmitter
   output logic          rxo_rd_wait,
   output logic          rx_overrun     // sticky until reset
);

   datamode_e pkt_mode;                  // transfer size of incoming packet

   assign pkt_mode = datamode_e'(pkt[datamode_msb:datamode_lsb]);

   //########################################
   // channel select
   //########################################
   always_ff @(posedge rx_lclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_wr_access <= 1'b0;
         rx_rd_access <= 1'b0;
         rx_burst     <= 1'b0;
      end
      else
      begin
         rx_wr_access <= pkt_valid &  pkt[write_bit];
         rx_rd_access <= pkt_valid & ~pkt[write_bit]; // no write means read
         if (pkt_valid)
            rx_burst <= pkt_burst;
      end
   end

   always_ff @(posedge rx_lclk)
   begin
      if (pkt_valid)
         rx_packet <= pkt;
   end

   //########################################
   // push-back and overrun
   //########################################
   always_ff @(posedge rx_lclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rxo_wr_wait <= 1'b0;
         rxo_rd_wait <= 1'b0;
         rx_overrun  <= 1'b0;
      end
      else
      begin
         rxo_wr_wait <= rx_wr_wait;
         rxo_rd_wait <= rx_rd_wait;
         // delivered anyway, just flagged
         if ((rx_wr_access && rxo_wr_wait) || (rx_rd_access && rxo_rd_wait))
            rx_overrun <= 1'b1;
      end
   end

   // each packet lands on exactly one channel
   a_one_channel : assert property (
      @(posedge rx_lclk) disable iff (!rst_n)
      pkt_valid |=> $onehot({rx_wr_access, rx_rd_access}));

   // upstream frames carry a real transaction
   a_access_set : assert property (
      @(posedge rx_lclk) disable iff (!rst_n)
      pkt_valid |-> pkt[access_bit] && !$isunknown(pkt_mode));

endmodule

/* design/erx_top.sv */
`timescale 1ns/1ns

// receive path, three register stages on rx_lclk
module erx_top
   import elink_pkg::*, erx_pkg::*;
#(
   parameter int PW = pkt_w
)
(
   input  logic          rx_lclk,
   input  logic          rst_n,
   input  logic          rx_frame,
   input  logic [15:0]   rx_word,       // both edges of the byte lane
   input  logic          rx_wr_wait,
   input  logic          rx_rd_wait,
   output logic          rx_wr_access,
   output logic          rx_rd_access,
   output logic [PW-1:0] rx_packet,
   output logic          rx_burst,
   output logic          rxo_wr_wait,
   output logic          rxo_rd_wait,
   output logic          rx_overrun
);

   //########################################
   // stage links
   //########################################
   logic                sample_valid;
   logic [sample_w-1:0] sample;
   logic                sample_burst;
   logic                pkt_valid;
   logic [PW-1:0]       pkt;
   logic                pkt_burst;

   erx_deframer u_deframer
   (
      .rx_lclk      (rx_lclk),
      .rst_n        (rst_n),
      .rx_frame     (rx_frame),
      .rx_word      (rx_word),
      .sample_valid (sample_valid),
      .sample       (sample),
      .sample_burst (sample_burst)
   );

   erx_unpack #(.PW(PW)) u_unpack
   (
      .rx_lclk      (rx_lclk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .sample       (sample),
      .sample_burst (sample_burst),
      .pkt_valid    (pkt_valid),
      .pkt          (pkt),
      .pkt_burst    (pkt_burst)
   );

   erx_router #(.PW(PW)) u_router
   (
      .rx_lclk      (rx_lclk),
      .rst_n        (rst_n),
      .pkt_valid    (pkt_valid),
      .pkt          (pkt),
      .pkt_burst    (pkt_burst),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait),
      .rx_wr_access (rx_wr_access),
      .rx_rd_access (rx_rd_access),
      .rx_packet    (rx_packet),
      .rx_burst     (rx_burst),
      .rxo_wr_wait  (rxo_wr_wait),
      .rxo_rd_wait  (rxo_rd_wait),
      .rx_overrun   (rx_overrun)
   );

endmodule

/* design/erx_unpack.sv */
`timescale 1ns/1ns

// stage 2: sample bytes reordered into the transaction packet
module erx_unpack
   import elink_pkg::*, erx_pkg::*;
#(
   parameter int PW = pkt_w
)
(
   input  logic                rx_lclk,
   input  logic                rst_n,
   input  logic                sample_valid,
   input  logic [sample_w-1:0] sample,
   input  logic                sample_burst,
   output logic                pkt_valid,    // sample_valid one cycle later
   output logic [PW-1:0]       pkt,
   output logic                pkt_burst
);

   //########################################
   // field shuffle
   //########################################
   always_ff @(posedge rx_lclk)
   begin
      if (sample_valid)
      begin
         pkt[access_bit]                  <= sample[40];
         pkt[write_bit]                   <= sample[41];
         pkt[datamode_msb:datamode_lsb]   <= sample[43:42];
         pkt[ctrlmode_msb:ctrlmode_lsb]   <= sample[15:12];
         // dstaddr straddles words 0 to 2
         pkt[dstaddr_msb:dstaddr_lsb]     <= {sample[11:8],
                                              sample[23:16],
                                              sample[31:24],
                                              sample[39:32],
                                              sample[47:44]};
         pkt[data_msb:data_lsb]           <= {sample[55:48],
                                              sample[63:56],
                                              sample[71:64],
                                              sample[79:72]}; // byte swapped
         pkt[srcaddr_msb:srcaddr_lsb]     <= {sample[87:80],
                                              sample[95:88],
                                              sample[103:96],
                                              sample[111:104]};
      end
   end

   always_ff @(posedge rx_lclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pkt_valid <= 1'b0;
         pkt_burst <= 1'b0;
      end
      else
      begin
         pkt_valid <= sample_valid;        // delayed strobe
         if (sample_valid)
            pkt_burst <= sample_burst;
      end
   end

   // field map is fixed at 104 bits
   a_pkt_width : assert property (@(posedge rx_lclk) PW == pkt_w);

endmodule

/* files.f */
+incdir+sim
design/elink_pkg.sv
design/erx_pkg.sv
design/erx_deframer.sv
design/erx_unpack.sv
design/erx_router.sv
design/erx_top.sv
sim/erx_tb.sv

/* sim/erx_tb_tasks.svh */
`ifndef ERX_TB_TASKS_SVH
`define ERX_TB_TASKS_SVH

//########################################
// reference field rule
//########################################
function automatic logic [103:0] pkt_model(input logic [111:0] s);
   logic [103:0] p;
   p[0]      = s[40];                   // access
   p[1]      = s[41];                   // write
   p[3:2]    = s[43:42];                // datamode
   p[7:4]    = s[15:12];                // ctrlmode
   p[39:8]   = {s[11:8], s[23:16], s[31:24], s[39:32], s[47:44]};
   p[71:40]  = {s[55:48], s[63:56], s[71:64], s[79:72]};   // data, bytes reversed
   p[103:72] = {s[87:80], s[95:88], s[103:96], s[111:104]};
   return p;
endfunction

// full frame of npkt packets, later packets refill slots 3 to 6
task automatic send_frame(input int npkt, input bit wr, input datamode_e mode);
   logic [111:0] smp;
   logic [15:0]  w;
   int           slot;
   int           nwords;
   nwords = 7 + 4 * (npkt - 1);
   smp    = '0;
   for (int i = 0; i < nwords; i++)
   begin
      slot = (i < 7) ? i : 3 + (i - 7) % 4;
      w    = 16'($random(seed));
      if (slot == 2)
      begin
         w[8]     = 1'b1;               // access always set
         w[9]     = wr;
         w[11:10] = mode;
      end
      smp[slot*16 +: 16] = w;           // slots 0 to 2 survive the burst
      @(posedge rx_lclk);
      rx_frame <= 1'b1;
      rx_word  <= w;
      if (slot == 6)
      begin
         exp_pkt.push_back(pkt_model(smp));
         exp_burst.push_back(i >= 7);   // not the first packet of the frame
         exp_due.push_back(cyc + 4);    // accept edge plus three stages
      end
   end
   @(posedge rx_lclk);
   rx_frame <= 1'b0;                    // idle cycle closes the frame
endtask

// frame cut short, nothing expected
task automatic send_short(input int nwords);
   for (int i = 0; i < nwords; i++)
   begin
      @(posedge rx_lclk);
      rx_frame <= 1'b1;
      rx_word  <= 16'($random(seed));
   end
   @(posedge rx_lclk);
   rx_frame <= 1'b0;
endtask

`endif

/* sim/erx_tb.sv */
`timescale 1ns/1ns

module erx_tb
   import elink_pkg::*;
();

   localparam int drain_max      = 16;                  // cycles to wait for a packet
   localparam int frame_max      = 7 + 4 * 2 + 1 + drain_max + 2;
   localparam int n_frames       = 30;
   localparam int timeout_cycles = 10 + n_frames * frame_max + 100;

   logic          rx_lclk;
   logic          rst_n;
   logic          rx_frame;
   logic [15:0]   rx_word;
   logic          rx_wr_wait;
   logic          rx_rd_wait;
   logic          rx_wr_access;
   logic          rx_rd_access;
   logic [pkt_w-1:0] rx_packet;
   logic          rx_burst;
   logic          rxo_wr_wait;
   logic          rxo_rd_wait;
   logic          rx_overrun;

   int            seed = 32'hd963_eb72;
   int            cyc;                                  // rising edges so far
   int            errors;
   int            packets;
   int            tests;
   logic [103:0]  exp_pkt[$];                           // expected packets in arrival order
   bit            exp_burst[$];
   int            exp_due[$];                           // cycle of the access pulse
   logic          wr_wait_q;
   logic          rd_wait_q;
   logic          ovr_exp;
   logic [103:0]  prev_pkt;

   erx_top #(.PW(pkt_w)) uut
   (
      .rx_lclk      (rx_lclk),
      .rst_n        (rst_n),
      .rx_frame     (rx_frame),
      .rx_word      (rx_word),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait),
      .rx_wr_access (rx_wr_access),
      .rx_rd_access (rx_rd_access),
      .rx_packet    (rx_packet),
      .rx_burst     (rx_burst),
      .rxo_wr_wait  (rxo_wr_wait),
      .rxo_rd_wait  (rxo_rd_wait),
      .rx_overrun   (rx_overrun)
   );

   `include "erx_tb_tasks.svh"

   initial
   begin
      rx_lclk = 1'b0;
      forever #2 rx_lclk = ~rx_lclk;                     // 4 ns period
   end

   initial
   begin
      repeat (timeout_cycles) @(posedge rx_lclk);
      $display("watchdog expired before the test sequence finished");
      $display("Simulation failed");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [103:0] got,
                                  input logic [103:0] exp);
      errors++;
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
   endtask

   task automatic test_done(input string name, input int err_start);
      tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - err_start);
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_pkt.size() != 0 && n < drain_max)
      begin
         @(posedge rx_lclk);                             // checker pops at negedge
         n++;
      end
      a_drained : assert (exp_pkt.size() == 0)
         else begin
            errors++;
            $display("%0d expected packets never arrived", exp_pkt.size());
         end
      exp_pkt.delete();
      exp_burst.delete();
      exp_due.delete();
      repeat (2) @(negedge rx_lclk);                     // stray pulses land here
   endtask

   //########################################
   // wait levels one cycle behind
   //########################################
   always @(posedge rx_lclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cyc       <= 0;
         wr_wait_q <= 1'b0;
         rd_wait_q <= 1'b0;
      end
      else
      begin
         cyc       <= cyc + 1;
         wr_wait_q <= rx_wr_wait;
         rd_wait_q <= rx_rd_wait;
      end
   end

   // outputs only sampled mid-cycle
   always @(negedge rx_lclk)
   begin
      logic [103:0] e;
      bit           eb;
      int           due;
      logic         ovr_next;
      ovr_next = 1'b0;
      if (!rst_n)
         ovr_exp = 1'b0;
      else
      begin
         if (rx_wr_access || rx_rd_access)
         begin
            packets++;
            a_pending : assert (exp_pkt.size() != 0)
               else begin
                  errors++;
                  $display("access pulse at cycle %0d with no packet pending", cyc);
               end
            if (exp_pkt.size() != 0)
            begin
               e   = exp_pkt.pop_front();
               eb  = exp_burst.pop_front();
               due = exp_due.pop_front();
               a_channel : assert (rx_wr_access == e[1] && rx_rd_access == !e[1])
                  else report_mismatch("rx_wr_access", rx_wr_access, e[1]);
               a_packet : assert (rx_packet == e)
                  else report_mismatch("rx_packet", rx_packet, e);
               a_burst : assert (rx_burst == eb)
                  else report_mismatch("rx_burst", rx_burst, eb);
               a_latency : assert (cyc == due)
                  else begin
                     errors++;
                     $display("access pulse at cycle %0d, expected at %0d", cyc, due);
                  end
               if (eb)                                   // control and dstaddr reused
                  a_keep : assert (rx_packet[39:0] == prev_pkt[39:0])
                     else report_mismatch("rx_packet[39:0]", rx_packet[39:0], prev_pkt[39:0]);
               prev_pkt = rx_packet;
               ovr_next = e[1] ? wr_wait_q : rd_wait_q; // expected channel under its wait
            end
         end
         a_wait : assert (rxo_wr_wait == wr_wait_q && rxo_rd_wait == rd_wait_q)
            else report_mismatch("rxo_wr_wait,rxo_rd_wait", {rxo_wr_wait, rxo_rd_wait},
                                 {wr_wait_q, rd_wait_q});
         a_overrun : assert (rx_overrun == ovr_exp)
            else report_mismatch("rx_overrun", rx_overrun, ovr_exp);
         if (ovr_next)
            ovr_exp = 1'b1;                              // shows up next cycle
      end
   end

   //########################################
   // test sequence
   //########################################
   initial
   begin
      int  e0;
      bit  wr;
      int  np;
      rst_n      = 1'b0;
      rx_frame   = 1'b0;
      rx_word    = '0;
      rx_wr_wait = 1'b0;
      rx_rd_wait = 1'b0;
      errors     = 0;
      packets    = 0;
      tests      = 0;
      repeat (10) @(posedge rx_lclk);
      rst_n <= 1'b1;
      @(negedge rx_lclk);
      a_reset : assert (!rx_wr_access && !rx_rd_access && !rx_overrun && !rxo_wr_wait
                        && !rxo_rd_wait)
         else begin
            errors++;
            $display("outputs not idle after reset");
         end

      e0 = errors;                                       // single write
      send_frame(1, 1'b1, dm_word);
      wait_drained();
      test_done("single write", e0);

      e0 = errors;                                       // single read
      send_frame(1, 1'b0, dm_byte);
      wait_drained();
      test_done("single read", e0);

      e0 = errors;                                       // three-packet burst
      send_frame(3, 1'b1, dm_double);
      wait_drained();
      test_done("burst of three", e0);

      e0 = errors;                                       // dropped then full frame
      send_short(5);
      repeat (8) @(negedge rx_lclk);
      send_frame(1, 1'b1, dm_half);
      wait_drained();
      test_done("dropped frame", e0);

      e0 = errors;                                       // wait forwarding and overrun
      @(posedge rx_lclk);
      rx_rd_wait <= 1'b1;
      repeat (3) @(posedge rx_lclk);
      rx_rd_wait <= 1'b0;
      rx_wr_wait <= 1'b1;
      send_frame(1, 1'b0, dm_half);
      wait_drained();
      a_no_ovr : assert (!rx_overrun)
         else report_mismatch("rx_overrun", rx_overrun, 1'b0);
      send_frame(1, 1'b1, dm_word);
      wait_drained();
      @(posedge rx_lclk);
      rx_wr_wait <= 1'b0;
      repeat (4) @(negedge rx_lclk);
      a_ovr_hold : assert (rx_overrun)
         else report_mismatch("rx_overrun", rx_overrun, 1'b1);
      test_done("wait and overrun", e0);

      e0 = errors;                                       // random frames
      for (int k = 0; k < 20; k++)
      begin
         wr = 1'($random(seed));
         np = 1 + int'($unsigned($random(seed)) % 3);
         send_frame(np, wr, datamode_e'(2'($random(seed))));
         wait_drained();
      end
      test_done("random frames", e0);

      $display("tests %0d, packets %0d, errors %0d", tests, packets, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
